// File: dv/event_builder_assert.sv
// bound protocol checks on the event builder fifo and daq link handshakes
module event_builder_assert (
  input logic                        clk,
  input logic                        rst,
  input logic                        trig_fifo_tvalid,
  input logic                        trig_fifo_tready,
  input logic                        pulse_fifo_tvalid,
  input logic                        pulse_fifo_tready,
  input logic                        daq_ready,
  input logic                        daq_almost_full,
  input logic                        daq_valid,
  input logic                        daq_header,
  input logic                        daq_trailer,
  input logic [amc13_pkg::DAQ_W-1:0] daq_data
);

  int fail_count = 0;  // read by the testbench at the end of the run

  trig_tready_with_tvalid: assert property (@(posedge clk) disable iff (rst)
    trig_fifo_tready |-> trig_fifo_tvalid)
    else begin
      $error("trigger fifo tready without tvalid");
      fail_count = fail_count + 1;
    end

  pulse_tready_with_tvalid: assert property (@(posedge clk) disable iff (rst)
    pulse_fifo_tready |-> pulse_fifo_tvalid)
    else begin
      $error("pulse fifo tready without tvalid");
      fail_count = fail_count + 1;
    end

  no_valid_when_full: assert property (@(posedge clk) disable iff (rst)
    !(daq_valid && daq_almost_full))
    else begin
      $error("daq_valid high while almost_full");
      fail_count = fail_count + 1;
    end

  header_trailer_apart: assert property (@(posedge clk) disable iff (rst)
    !(daq_header && daq_trailer))
    else begin
      $error("header and trailer flags set together");
      fail_count = fail_count + 1;
    end

  // a refused word must still be there on the next cycle
  stall_holds_word: assert property (@(posedge clk) disable iff (rst)
    (daq_valid && !daq_ready) |=>
      ($stable(daq_data) && $stable(daq_header) && $stable(daq_trailer)))
    else begin
      $error("daq word changed while stalled");
      fail_count = fail_count + 1;
    end

endmodule

bind event_builder event_builder_assert assert0 (.*);

// File: dv/event_builder_tb.sv
// testbench for the trigger board event builder, random events against a word model
module event_builder_tb;

  import amc13_pkg::*;
  import event_pkg::*;

  localparam int N_EVENTS      = 20;
  localparam int EVENT_TIMEOUT = 1000;  // cycles allowed per event

  logic                    clk;
  logic                    rst;
  logic                    ttc_trigger;
  logic                    trig_fifo_tvalid;
  logic                    trig_fifo_tready;
  logic [TRIG_FIFO_W-1:0]  trig_fifo_tdata;
  logic                    pulse_fifo_tvalid;
  logic                    pulse_fifo_tready;
  logic [PULSE_FIFO_W-1:0] pulse_fifo_tdata;
  logic                    l12_tts_lock_mux;
  logic                    l8_tts_lock_mux;
  logic                    ext_clk_lock;
  logic                    ttc_clk_lock;
  logic                    ttc_ready;
  logic [XADC_W-1:0]       xadc_alarms;
  logic                    error_flag;
  logic                    error_l12_fmc_absent;
  logic                    error_l8_fmc_absent;
  logic [BOARD_ID_W-1:0]   board_id;
  logic [FMC_ID_W-1:0]     l12_fmc_id;
  logic [FMC_ID_W-1:0]     l8_fmc_id;
  logic                    daq_ready;
  logic                    daq_almost_full;
  logic                    daq_valid;
  logic                    daq_header;
  logic                    daq_trailer;
  logic [DAQ_W-1:0]        daq_data;

  // current event, as the model sees it
  logic [TS_W-1:0]     ev_ts;
  logic [TNUM_W-1:0]   ev_num;
  logic [TTYPE_W-1:0]  ev_type;
  logic [TDELAY_W-1:0] ev_delay;
  logic [TIDX_W-1:0]   ev_idx;
  logic [TIDX_W-1:0]   ev_sub;
  logic [SNAP_W-1:0]   ev_status;  // status on the trigger cycle
  logic [DAQ_W-1:0]    ev_pulse [PULSE_WORDS];
  logic [DAQ_W-1:0]    exp_words [EVENT_WORDS];

  logic [DAQ_W-1:0] got_data [$];
  logic             got_hdr [$];
  logic             got_trl [$];

  event_builder dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("FAIL: see errors above");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [DAQ_W-1:0] exp,
                            input logic [DAQ_W-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
      stop_on_failure();
    end
  endtask

  // spread one status vector over the status pins
  task automatic drive_status(input logic [SNAP_W-1:0] r);
    error_l12_fmc_absent = r[0];
    error_l8_fmc_absent  = r[1];
    ttc_ready            = r[2];
    ttc_clk_lock         = r[3];
    ext_clk_lock         = r[4];
    l12_tts_lock_mux     = r[5];
    l8_tts_lock_mux      = r[6];
    error_flag           = r[7];
    xadc_alarms          = r[11:8];
  endtask

  task automatic drive_link();
    daq_ready       = ($urandom % 10) < 7;   // about 70 percent
    daq_almost_full = ($urandom % 10) == 0;
  endtask

  // monitor, samples mid-cycle ahead of the transfer edge
  task automatic collect_transfer(output logic last);
    last = 1'b0;
    if (daq_valid && daq_ready) begin
      got_data.push_back(daq_data);
      got_hdr.push_back(daq_header);
      got_trl.push_back(daq_trailer);
      last = daq_trailer;
    end
  endtask

  task automatic build_expected();
    logic [DAQ_W-1:0] w;
    w = '0;
    w[19:0]  = LEN_W'(EVENT_WORDS);
    w[31:20] = ev_ts[43:32];
    w[55:32] = ev_num;
    exp_words[0] = w;
    w = '0;
    w[10:0]  = board_id - 11'd90;  // board serial
    w[12:11] = BOARD_TYPE;
    w[15:13] = HDR2_TAG;
    w[47:16] = ev_ts[31:0];
    w[52:48] = ev_type;
    w[53]    = ev_status[7];
    w[57:54] = ev_status[11:8];
    exp_words[1] = w;
    w = '0;
    w[7:0]   = FW_PATCH;
    w[15:8]  = FW_MINOR;
    w[23:16] = FW_MAJOR;
    exp_words[2] = w;
    w = '0;
    w[7:0]   = l12_fmc_id;
    w[15:8]  = l8_fmc_id;
    w[19:16] = ev_idx;
    w[23:20] = ev_sub;
    w[30:24] = ev_status[6:0];
    w[63:32] = ev_delay;
    exp_words[3] = w;
    for (int i = 0; i < PULSE_WORDS; i++) exp_words[4 + i] = ev_pulse[i];
    w = '0;
    w[19:0]  = LEN_W'(EVENT_WORDS);
    w[31:24] = ev_num[7:0];
    exp_words[36] = w;
  endtask

  task automatic run_event(input int e);
    logic [TRIG_FIFO_W-1:0]  tword;
    logic [PULSE_FIFO_W-1:0] pword;
    int   trig_wait;
    int   pulse_wait;
    int   trig_rdy_cnt;
    int   pulse_rdy_cnt;
    int   cyc;
    logic trig_taken;
    logic pulse_taken;
    logic last;
    logic done;
    ev_ts    = TS_W'({$urandom, $urandom});
    ev_num   = TNUM_W'($urandom);
    ev_type  = TTYPE_W'($urandom);
    ev_delay = $urandom;
    ev_idx   = TIDX_W'($urandom);
    ev_sub   = TIDX_W'($urandom);
    tword    = {$urandom, $urandom, $urandom, $urandom};  // spare bits stay random
    tword[TS_LSB +: TS_W]         = ev_ts;
    tword[TNUM_LSB +: TNUM_W]     = ev_num;
    tword[TTYPE_LSB +: TTYPE_W]   = ev_type;
    tword[TDELAY_LSB +: TDELAY_W] = ev_delay;
    tword[TIDX_LSB +: TIDX_W]     = ev_idx;
    tword[TSUB_LSB +: TIDX_W]     = ev_sub;
    for (int i = 0; i < PULSE_WORDS; i++) begin
      ev_pulse[i] = {$urandom, $urandom};
      pword[i*DAQ_W +: DAQ_W] = ev_pulse[i];
    end
    trig_wait     = $urandom % 5;
    pulse_wait    = $urandom % 5;
    trig_rdy_cnt  = 0;
    pulse_rdy_cnt = 0;
    trig_taken    = 1'b0;
    pulse_taken   = 1'b0;
    done          = 1'b0;
    cyc           = 0;
    got_data.delete();
    got_hdr.delete();
    got_trl.delete();
    @(posedge clk);
    #2;
    ttc_trigger = 1'b1;
    ev_status   = SNAP_W'($urandom);
    drive_status(ev_status);
    drive_link();
    trig_fifo_tvalid  = 1'b0;
    trig_fifo_tdata   = ~tword;  // junk until valid
    pulse_fifo_tvalid = 1'b0;
    pulse_fifo_tdata  = ~pword;
    build_expected();
    while (!done) begin
      @(negedge clk);
      collect_transfer(last);
      if (trig_fifo_tready) begin
        trig_taken = 1'b1;
        trig_rdy_cnt++;
      end
      if (pulse_fifo_tready) begin
        pulse_taken = 1'b1;
        pulse_rdy_cnt++;
      end
      done = last || (got_data.size() >= EVENT_WORDS);
      cyc++;
      if (!done && cyc >= EVENT_TIMEOUT) begin
        $display("event %0d did not finish within %0d cycles", e, EVENT_TIMEOUT);
        stop_on_failure();
      end
      if (!done) begin
        @(posedge clk);
        #2;
        ttc_trigger = ($urandom % 8) == 0;  // mid-event triggers must be ignored
        drive_status(SNAP_W'($urandom));
        drive_link();
        // fifos keep offering the next word once theirs has been taken
        trig_fifo_tvalid = trig_taken || (trig_wait == 0);
        trig_fifo_tdata  = (trig_fifo_tvalid && !trig_taken) ? tword : ~tword;
        if (!trig_taken && trig_wait > 0) trig_wait--;
        pulse_fifo_tvalid = pulse_taken || (trig_taken && pulse_wait == 0);
        pulse_fifo_tdata  = (pulse_fifo_tvalid && !pulse_taken) ? pword : ~pword;
        if (trig_taken && !pulse_taken && pulse_wait > 0) pulse_wait--;
      end
    end
    check_count($sformatf("event %0d word count", e), EVENT_WORDS, got_data.size());
    for (int i = 0; i < EVENT_WORDS; i++) begin
      check_word($sformatf("event %0d word %0d", e, i), exp_words[i], got_data[i]);
      check_flag($sformatf("event %0d word %0d header", e, i), i == 0, got_hdr[i]);
      check_flag($sformatf("event %0d word %0d trailer", e, i), i == TRAILER_IDX, got_trl[i]);
    end
    check_count($sformatf("event %0d trig tready pulses", e), 1, trig_rdy_cnt);
    check_count($sformatf("event %0d pulse tready pulses", e), 1, pulse_rdy_cnt);
  endtask

  initial begin
    void'($urandom(32'h3a8c));
    rst               = 1'b1;
    ttc_trigger       = 1'b0;
    trig_fifo_tvalid  = 1'b0;
    trig_fifo_tdata   = '0;
    pulse_fifo_tvalid = 1'b0;
    pulse_fifo_tdata  = '0;
    daq_ready         = 1'b0;
    daq_almost_full   = 1'b0;
    drive_status('0);
    board_id   = BOARD_ID_W'($urandom);
    l12_fmc_id = FMC_ID_W'($urandom);
    l8_fmc_id  = FMC_ID_W'($urandom);
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    // fifos offer data but no trigger yet, so nothing may move
    repeat (6) begin
      @(posedge clk);
      #2;
      trig_fifo_tvalid  = 1'b1;
      pulse_fifo_tvalid = 1'b1;
      drive_link();
      @(negedge clk);
      check_flag("idle trig tready", 1'b0, trig_fifo_tready);
      check_flag("idle pulse tready", 1'b0, pulse_fifo_tready);
      check_flag("idle daq_valid", 1'b0, daq_valid);
      check_flag("idle daq_header", 1'b0, daq_header);
      check_flag("idle daq_trailer", 1'b0, daq_trailer);
    end
    for (int e = 0; e < N_EVENTS; e++) run_event(e);
    // fifos still offer data, so a latched trigger would start an extra event
    repeat (20) begin
      @(posedge clk);
      #2;
      ttc_trigger = 1'b0;
      drive_status(SNAP_W'($urandom));
      drive_link();
      @(negedge clk);
      check_flag("daq_valid after last event", 1'b0, daq_valid);
    end
    if (dut0.assert0.fail_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("%0d assertion failures reported", dut0.assert0.fail_count);
      stop_on_failure();
    end
  end

endmodule

// File: event_builder.f
hw/amc13_pkg.sv
hw/event_pkg.sv
hw/trig_info_capture.sv
hw/pulse_info_buffer.sv
hw/daq_word_formatter.sv
hw/event_fsm.sv
hw/event_builder.sv
dv/event_builder_assert.sv
dv/event_builder_tb.sv

// File: hw/amc13_pkg.sv
// amc13 daq link word format, event length and word positions
package amc13_pkg;

  // link word
  localparam int DAQ_W = 64;

  // event length, also carried in the header and trailer length field
  localparam int EVENT_WORDS = 37;
  localparam int LEN_W       = 20;

  // word positions inside one event
  localparam int HDR_WORD_IDX    = 0;  // amc13 header
  localparam int BOARD_WORD_IDX  = 1;  // board header
  localparam int REV_WORD_IDX    = 2;  // firmware revision
  localparam int STATUS_WORD_IDX = 3;  // trigger status
  localparam int PULSE_FIRST_IDX = 4;
  localparam int TRAILER_IDX     = 36;

  // counter wide enough to reach EVENT_WORDS
  localparam int WORD_IDX_W = 6;

  // fixed tag in the board header
  localparam logic [2:0] HDR2_TAG = 3'd2;

endpackage

// File: hw/daq_word_formatter.sv
// builds each daq link word by position and registers it with header and trailer flags
module daq_word_formatter (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                word_load,
  input  logic [amc13_pkg::WORD_IDX_W-1:0]    word_idx,
  input  logic [event_pkg::TS_W-1:0]          trig_ts,
  input  logic [event_pkg::TNUM_W-1:0]        trig_num,
  input  logic [event_pkg::TTYPE_W-1:0]       trig_type,
  input  logic [event_pkg::TDELAY_W-1:0]      trig_delay,
  input  logic [event_pkg::TIDX_W-1:0]        trig_index,
  input  logic [event_pkg::TIDX_W-1:0]        trig_sub_index,
  input  logic [event_pkg::SNAP_W-1:0]        snap,
  input  logic [amc13_pkg::DAQ_W-1:0]         pulse_head,
  input  logic [event_pkg::BOARD_ID_W-1:0]    board_id,
  input  logic [event_pkg::FMC_ID_W-1:0]      l12_fmc_id,
  input  logic [event_pkg::FMC_ID_W-1:0]      l8_fmc_id,
  output logic                                pulse_pop,
  output logic [amc13_pkg::DAQ_W-1:0]         daq_data,
  output logic                                daq_header,
  output logic                                daq_trailer
);

  import amc13_pkg::*;
  import event_pkg::*;

  logic [BOARD_ID_W-1:0] board_sn;
  logic [DAQ_W-1:0]      amc13_hdr_word;
  logic [DAQ_W-1:0]      board_hdr_word;
  logic [DAQ_W-1:0]      rev_word;
  logic [DAQ_W-1:0]      status_word;
  logic [DAQ_W-1:0]      trailer_word;
  logic [DAQ_W-1:0]      word_d;
  logic                  is_pulse;

  assign board_sn = board_id - BOARD_ID_W'(BOARD_SN_OFFSET);

  assign amc13_hdr_word = {8'h00, trig_num, trig_ts[TS_W-1:32], LEN_W'(EVENT_WORDS)};

  // alarms and error flag come from the snapshot, not the live pins
  assign board_hdr_word = {6'd0,
                           snap[SNAP_XADC_LSB +: XADC_W],
                           snap[SNAP_ERROR_FLAG],
                           trig_type,
                           trig_ts[31:0],
                           HDR2_TAG,
                           BOARD_TYPE,
                           board_sn};

  assign rev_word = {40'd0, FW_MAJOR, FW_MINOR, FW_PATCH};

  assign status_word = {trig_delay,
                        1'b0,
                        snap[SNAP_STATUS_W-1:0],  // locks, ttc ready, fmc absent
                        trig_sub_index,
                        trig_index,
                        l8_fmc_id,
                        l12_fmc_id};

  assign trailer_word = {32'd0, trig_num[7:0], 4'h0, LEN_W'(EVENT_WORDS)};

  always_comb begin
    case (word_idx)
      WORD_IDX_W'(HDR_WORD_IDX):    word_d = amc13_hdr_word;
      WORD_IDX_W'(BOARD_WORD_IDX):  word_d = board_hdr_word;
      WORD_IDX_W'(REV_WORD_IDX):    word_d = rev_word;
      WORD_IDX_W'(STATUS_WORD_IDX): word_d = status_word;
      WORD_IDX_W'(TRAILER_IDX):     word_d = trailer_word;
      default:                      word_d = pulse_head;
    endcase
  end

  // head word consumed whenever it is taken into the output register
  assign is_pulse  = (word_idx >= WORD_IDX_W'(PULSE_FIRST_IDX)) &&
                     (word_idx <  WORD_IDX_W'(TRAILER_IDX));
  assign pulse_pop = word_load && is_pulse;

  always_ff @(posedge clk) begin
    if (word_load) begin
      daq_data <= word_d;  // held until the next load
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      daq_header  <= 1'b0;
      daq_trailer <= 1'b0;
    end else if (word_load) begin
      daq_header  <= (word_idx == WORD_IDX_W'(HDR_WORD_IDX));
      daq_trailer <= (word_idx == WORD_IDX_W'(TRAILER_IDX));
    end
  end

endmodule

// File: hw/event_builder.sv
// trigger board event builder, fifo reads to amc13 daq link words
module event_builder (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                ttc_trigger,
  // trigger info fifo
  input  logic                                trig_fifo_tvalid,
  output logic                                trig_fifo_tready,
  input  logic [event_pkg::TRIG_FIFO_W-1:0]   trig_fifo_tdata,
  // pulse info fifo
  input  logic                                pulse_fifo_tvalid,
  output logic                                pulse_fifo_tready,
  input  logic [event_pkg::PULSE_FIFO_W-1:0]  pulse_fifo_tdata,
  // variable status
  input  logic                                l12_tts_lock_mux,
  input  logic                                l8_tts_lock_mux,
  input  logic                                ext_clk_lock,
  input  logic                                ttc_clk_lock,
  input  logic                                ttc_ready,
  input  logic [event_pkg::XADC_W-1:0]        xadc_alarms,
  input  logic                                error_flag,
  input  logic                                error_l12_fmc_absent,
  input  logic                                error_l8_fmc_absent,
  // static board info
  input  logic [event_pkg::BOARD_ID_W-1:0]    board_id,
  input  logic [event_pkg::FMC_ID_W-1:0]      l12_fmc_id,
  input  logic [event_pkg::FMC_ID_W-1:0]      l8_fmc_id,
  // amc13 daq link
  input  logic                                daq_ready,
  input  logic                                daq_almost_full,
  output logic                                daq_valid,
  output logic                                daq_header,
  output logic                                daq_trailer,
  output logic [amc13_pkg::DAQ_W-1:0]         daq_data
);

  import amc13_pkg::*;
  import event_pkg::*;

  logic                  snap_en;
  logic                  word_load;
  logic [WORD_IDX_W-1:0] word_idx;
  logic                  pulse_pop;
  logic [DAQ_W-1:0]      pulse_head;
  logic [TS_W-1:0]       trig_ts;
  logic [TNUM_W-1:0]     trig_num;
  logic [TTYPE_W-1:0]    trig_type;
  logic [TDELAY_W-1:0]   trig_delay;
  logic [TIDX_W-1:0]     trig_index;
  logic [TIDX_W-1:0]     trig_sub_index;
  logic [SNAP_W-1:0]     status;
  logic [SNAP_W-1:0]     snap;

  // gather the live status pins into snapshot order
  assign status[SNAP_L12_FMC_ABSENT]          = error_l12_fmc_absent;
  assign status[SNAP_L8_FMC_ABSENT]           = error_l8_fmc_absent;
  assign status[SNAP_TTC_READY]               = ttc_ready;
  assign status[SNAP_TTC_CLK_LOCK]            = ttc_clk_lock;
  assign status[SNAP_EXT_CLK_LOCK]            = ext_clk_lock;
  assign status[SNAP_L12_TTS_LOCK_MUX]        = l12_tts_lock_mux;
  assign status[SNAP_L8_TTS_LOCK_MUX]         = l8_tts_lock_mux;
  assign status[SNAP_ERROR_FLAG]              = error_flag;
  assign status[SNAP_XADC_LSB +: XADC_W]      = xadc_alarms;

  event_fsm fsm0 (
    .clk               (clk),
    .rst               (rst),
    .ttc_trigger       (ttc_trigger),
    .trig_fifo_tvalid  (trig_fifo_tvalid),
    .pulse_fifo_tvalid (pulse_fifo_tvalid),
    .daq_ready         (daq_ready),
    .daq_almost_full   (daq_almost_full),
    .trig_fifo_tready  (trig_fifo_tready),
    .pulse_fifo_tready (pulse_fifo_tready),
    .snap_en           (snap_en),
    .word_load         (word_load),
    .word_idx          (word_idx),
    .daq_valid         (daq_valid)
  );

  trig_info_capture capture0 (
    .clk              (clk),
    .rst              (rst),
    .snap_en          (snap_en),
    .trig_fifo_tready (trig_fifo_tready),
    .trig_fifo_tdata  (trig_fifo_tdata),
    .status           (status),
    .trig_ts          (trig_ts),
    .trig_num         (trig_num),
    .trig_type        (trig_type),
    .trig_delay       (trig_delay),
    .trig_index       (trig_index),
    .trig_sub_index   (trig_sub_index),
    .snap             (snap)
  );

  pulse_info_buffer pulse0 (
    .clk               (clk),
    .rst               (rst),
    .pulse_fifo_tready (pulse_fifo_tready),
    .pulse_fifo_tdata  (pulse_fifo_tdata),
    .pulse_pop         (pulse_pop),
    .pulse_head        (pulse_head)
  );

  daq_word_formatter fmt0 (
    .clk            (clk),
    .rst            (rst),
    .word_load      (word_load),
    .word_idx       (word_idx),
    .trig_ts        (trig_ts),
    .trig_num       (trig_num),
    .trig_type      (trig_type),
    .trig_delay     (trig_delay),
    .trig_index     (trig_index),
    .trig_sub_index (trig_sub_index),
    .snap           (snap),
    .pulse_head     (pulse_head),
    .board_id       (board_id),
    .l12_fmc_id     (l12_fmc_id),
    .l8_fmc_id      (l8_fmc_id),
    .pulse_pop      (pulse_pop),
    .daq_data       (daq_data),
    .daq_header     (daq_header),
    .daq_trailer    (daq_trailer)
  );

endmodule

// File: hw/event_fsm.sv
// event sequencing fsm: trigger, fifo reads, word counter and daq valid
module event_fsm (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             ttc_trigger,
  input  logic                             trig_fifo_tvalid,
  input  logic                             pulse_fifo_tvalid,
  input  logic                             daq_ready,
  input  logic                             daq_almost_full,
  output logic                             trig_fifo_tready,
  output logic                             pulse_fifo_tready,
  output logic                             snap_en,
  output logic                             word_load,
  output logic [amc13_pkg::WORD_IDX_W-1:0] word_idx,
  output logic                             daq_valid
);

  import amc13_pkg::*;
  import event_pkg::*;

  logic [STATE_W-1:0] state;
  logic               pending;   // output register holds an unsent word
  logic               xfer;
  logic               last_out;

  assign xfer = daq_valid && daq_ready;

  // word_idx already points past the trailer once it is in the output register
  assign last_out = (word_idx == WORD_IDX_W'(TRAILER_IDX + 1));

  assign snap_en           = (state == st_idle) && ttc_trigger;
  assign trig_fifo_tready  = (state == st_read_trig) && trig_fifo_tvalid;
  assign pulse_fifo_tready = (state == st_read_pulse) && pulse_fifo_tvalid;

  // first load on entry to send, then one load per transfer
  assign word_load = (state == st_send) && (!pending || (xfer && !last_out));

  assign daq_valid = pending && !daq_almost_full;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (snap_en) state <= st_read_trig;  // later triggers ignored until idle
        end
        st_read_trig: begin
          if (trig_fifo_tready) state <= st_read_pulse;
        end
        st_read_pulse: begin
          if (pulse_fifo_tready) state <= st_send;
        end
        st_send: begin
          if (xfer && last_out) state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending  <= 1'b0;
      word_idx <= '0;
    end else begin
      if (word_load) begin
        pending  <= 1'b1;
        word_idx <= word_idx + 1'b1;
      end else if (xfer) begin
        pending <= 1'b0;
      end
      if (xfer && last_out) begin
        word_idx <= '0;  // ready for the next event
      end
    end
  end

endmodule

// File: hw/event_pkg.sv
// trigger event layout: fifo fields, status snapshot, fsm states and board constants
package event_pkg;

  // trigger info fifo word
  localparam int TRIG_FIFO_W = 128;
  localparam int TS_W        = 44;
  localparam int TNUM_W      = 24;
  localparam int TTYPE_W     = 5;
  localparam int TDELAY_W    = 32;
  localparam int TIDX_W      = 4;   // index and sub-index

  localparam int TS_LSB     = 0;
  localparam int TNUM_LSB   = 44;
  localparam int TTYPE_LSB  = 68;
  localparam int TDELAY_LSB = 73;
  localparam int TIDX_LSB   = 105;
  localparam int TSUB_LSB   = 109;

  // pulse info fifo word, 32 link words
  localparam int PULSE_WORDS  = 32;
  localparam int PULSE_FIFO_W = 2048;

  // board identity
  localparam logic [1:0] BOARD_TYPE = 2'd3;  // trigger board
  localparam int BOARD_ID_W      = 11;
  localparam int BOARD_SN_OFFSET = 90;
  localparam int FMC_ID_W        = 8;

  localparam logic [7:0] FW_MAJOR = 8'h02;
  localparam logic [7:0] FW_MINOR = 8'h05;
  localparam logic [7:0] FW_PATCH = 8'h01;

  // status snapshot bits, low 7 bits go straight into the status word
  localparam int SNAP_W                = 12;
  localparam int SNAP_STATUS_W         = 7;
  localparam int SNAP_L12_FMC_ABSENT   = 0;
  localparam int SNAP_L8_FMC_ABSENT    = 1;
  localparam int SNAP_TTC_READY        = 2;
  localparam int SNAP_TTC_CLK_LOCK     = 3;
  localparam int SNAP_EXT_CLK_LOCK     = 4;
  localparam int SNAP_L12_TTS_LOCK_MUX = 5;
  localparam int SNAP_L8_TTS_LOCK_MUX  = 6;
  localparam int SNAP_ERROR_FLAG       = 7;
  localparam int SNAP_XADC_LSB         = 8;
  localparam int XADC_W                = 4;

  // fsm state codes
  localparam int STATE_W = 2;
  localparam logic [STATE_W-1:0] st_idle       = 2'd0;
  localparam logic [STATE_W-1:0] st_read_trig  = 2'd1;
  localparam logic [STATE_W-1:0] st_read_pulse = 2'd2;
  localparam logic [STATE_W-1:0] st_send       = 2'd3;

endpackage

// File: hw/pulse_info_buffer.sv
// pulse info word buffer, loads 32 link words and shifts them out in order
module pulse_info_buffer (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               pulse_fifo_tready,
  input  logic [event_pkg::PULSE_FIFO_W-1:0] pulse_fifo_tdata,
  input  logic                               pulse_pop,
  output logic [amc13_pkg::DAQ_W-1:0]        pulse_head
);

  import amc13_pkg::*;
  import event_pkg::*;

  logic [PULSE_WORDS-1:0][DAQ_W-1:0] pulse_q;  // element 0 is the head
  logic [PULSE_WORDS-1:0]            word_vld;

  always_ff @(posedge clk) begin
    if (pulse_fifo_tready) begin
      pulse_q <= pulse_fifo_tdata;  // word 0 sits in the low bits
    end else if (pulse_pop) begin
      pulse_q <= pulse_q >> DAQ_W;
    end
  end

  // tracks which slots still hold an unsent word
  always_ff @(posedge clk) begin
    if (rst) begin
      word_vld <= '0;
    end else if (pulse_fifo_tready) begin
      word_vld <= '1;
    end else if (pulse_pop) begin
      word_vld <= word_vld >> 1;
    end
  end

  // drained buffer reads as zero
  assign pulse_head = word_vld[0] ? pulse_q[0] : '0;

endmodule

// File: hw/trig_info_capture.sv
// trigger fifo field capture and per-event status snapshot
module trig_info_capture (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            snap_en,
  input  logic                            trig_fifo_tready,
  input  logic [event_pkg::TRIG_FIFO_W-1:0] trig_fifo_tdata,
  input  logic [event_pkg::SNAP_W-1:0]      status,
  output logic [event_pkg::TS_W-1:0]        trig_ts,
  output logic [event_pkg::TNUM_W-1:0]      trig_num,
  output logic [event_pkg::TTYPE_W-1:0]     trig_type,
  output logic [event_pkg::TDELAY_W-1:0]    trig_delay,
  output logic [event_pkg::TIDX_W-1:0]      trig_index,
  output logic [event_pkg::TIDX_W-1:0]      trig_sub_index,
  output logic [event_pkg::SNAP_W-1:0]      snap
);

  import event_pkg::*;

  // tready is only raised together with tvalid, so it marks the accepted word
  always_ff @(posedge clk) begin
    if (trig_fifo_tready) begin
      trig_ts        <= trig_fifo_tdata[TS_LSB     +: TS_W];
      trig_num       <= trig_fifo_tdata[TNUM_LSB   +: TNUM_W];
      trig_type      <= trig_fifo_tdata[TTYPE_LSB  +: TTYPE_W];
      trig_delay     <= trig_fifo_tdata[TDELAY_LSB +: TDELAY_W];
      trig_index     <= trig_fifo_tdata[TIDX_LSB   +: TIDX_W];
      trig_sub_index <= trig_fifo_tdata[TSUB_LSB   +: TIDX_W];
    end
  end

  // status frozen at the trigger cycle for the whole event
  always_ff @(posedge clk) begin
    if (rst) begin
      snap <= '0;
    end else if (snap_en) begin
      snap <= status;
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# builds the event builder testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module event_builder_tb -f event_builder.f \
  --Mdir obj_dir -o sim_event_builder
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_event_builder 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q '^PASS: all tests$'; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
